//--- common/spectrum_pkg.sv
package spectrum_pkg;

    localparam int frame_len = 16;       // samples per frame
    localparam int addr_w    = 4;        // buffer address and bin index
    localparam int sample_w  = 8;        // signed audio sample
    localparam int tw_w      = 16;       // signed Q1.14 twiddle
    localparam int acc_w     = 32;       // full precision sum
    localparam int bin_w     = 24;       // each output part
    localparam int out_shift = 8;        // arithmetic shift before truncation

    // sine of index m is read at (m - quarter) mod frame_len
    localparam int quarter   = frame_len / 4;

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic signed [tw_w-1:0]     twiddle_t;

    // re in the upper half, im in the lower half
    typedef struct packed {
        logic signed [bin_w-1:0] re;
        logic signed [bin_w-1:0] im;
    } bin_t;

    // round(16384 * cos(2*pi*m/16))
    localparam twiddle_t cos_table [frame_len] = '{
        16'sd16384,
        16'sd15137,
        16'sd11585,
        16'sd6270,
        16'sd0,
        -16'sd6270,
        -16'sd11585,
        -16'sd15137,
        -16'sd16384,
        -16'sd15137,
        -16'sd11585,
        -16'sd6270,
        16'sd0,
        16'sd6270,
        16'sd11585,
        16'sd15137
    };

endpackage

//--- hw/sample_framer.sv
`timescale 1ns/1ps

module sample_framer (
    input  logic                                      clk_in,
    input  logic                                      rst_in,
    input  logic signed [spectrum_pkg::sample_w-1:0]  sample,
    input  logic                                      sample_valid,
    input  logic                                      busy,
    output logic                                      ready,
    output logic                                      wr_en,
    output logic        [spectrum_pkg::addr_w-1:0]    wr_addr,
    output logic signed [spectrum_pkg::sample_w-1:0]  wr_data,
    output logic                                      frame_start
);

    logic [spectrum_pkg::addr_w-1:0] sample_cnt;    // wraps every frame
    logic                            accept;
    logic                            last_sample;

    // closed while a finished frame waits for the engine or is in work
    assign ready = !frame_start && !busy;

    assign accept      = sample_valid && ready;
    assign last_sample = (sample_cnt == spectrum_pkg::addr_w'(spectrum_pkg::frame_len - 1));

    assign wr_en   = accept;       // same edge as the accept
    assign wr_addr = sample_cnt;
    assign wr_data = sample;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sample_cnt  <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            if (accept) begin
                sample_cnt  <= sample_cnt + spectrum_pkg::addr_w'(1);  // rolls over
                frame_start <= last_sample;    // 16th sample closes the frame
            end
        end
    end

endmodule

//--- dft/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
    input  logic                                      clk_in,
    input  logic                                      wr_en,
    input  logic        [spectrum_pkg::addr_w-1:0]    wr_addr,
    input  logic signed [spectrum_pkg::sample_w-1:0]  wr_data,
    input  logic        [spectrum_pkg::addr_w-1:0]    rd_addr,
    output logic signed [spectrum_pkg::sample_w-1:0]  rd_data
);

    // one full frame of samples
    spectrum_pkg::sample_t mem [spectrum_pkg::frame_len];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];    // one cycle read latency
    end

endmodule

//--- dft/dft_engine.sv
`timescale 1ns/1ps

module dft_engine (
    input  logic                                      clk_in,
    input  logic                                      rst_in,
    input  logic                                      frame_start,
    output logic        [spectrum_pkg::addr_w-1:0]    rd_addr,
    input  logic signed [spectrum_pkg::sample_w-1:0]  rd_data,
    output logic                                      busy,
    output spectrum_pkg::bin_t                        bin,
    output logic                                      bin_valid,
    output logic                                      bin_last
);

    logic                                    mac_on;    // rd_data holds x[n]
    logic        [spectrum_pkg::addr_w-1:0]  n;
    logic        [spectrum_pkg::addr_w-1:0]  k;
    logic        [spectrum_pkg::addr_w-1:0]  cos_idx;
    logic        [spectrum_pkg::addr_w-1:0]  sin_idx;
    spectrum_pkg::twiddle_t                  cos_val;
    spectrum_pkg::twiddle_t                  sin_val;
    logic signed [spectrum_pkg::acc_w-1:0]   prod_re;
    logic signed [spectrum_pkg::acc_w-1:0]   prod_im;
    logic signed [spectrum_pkg::acc_w-1:0]   acc_re;
    logic signed [spectrum_pkg::acc_w-1:0]   acc_im;
    logic signed [spectrum_pkg::acc_w-1:0]   sum_re;
    logic signed [spectrum_pkg::acc_w-1:0]   sum_im;
    logic                                    last_tap;
    logic                                    last_bin;
    logic                                    start_frame;

    assign start_frame = frame_start && !busy;

    // address runs one ahead of the data; x[0] is fetched while idle or in the output cycle
    assign rd_addr = mac_on ? n + spectrum_pkg::addr_w'(1) : '0;

    // 4-bit product wraps to (n*k) mod 16
    assign cos_idx = n * k;
    assign sin_idx = cos_idx - spectrum_pkg::addr_w'(spectrum_pkg::quarter);

    assign cos_val = spectrum_pkg::cos_table[cos_idx];
    assign sin_val = spectrum_pkg::cos_table[sin_idx];

    assign prod_re = spectrum_pkg::acc_w'(rd_data) * spectrum_pkg::acc_w'(cos_val);
    assign prod_im = spectrum_pkg::acc_w'(rd_data) * spectrum_pkg::acc_w'(sin_val);

    assign sum_re = acc_re + prod_re;
    assign sum_im = acc_im - prod_im;    // negative sine term

    assign last_tap = (n == spectrum_pkg::addr_w'(spectrum_pkg::frame_len - 1));
    assign last_bin = (k == spectrum_pkg::addr_w'(spectrum_pkg::frame_len - 1));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy      <= 1'b0;
            mac_on    <= 1'b0;
            n         <= '0;
            k         <= '0;
            bin_valid <= 1'b0;
            bin_last  <= 1'b0;
        end else begin
            bin_valid <= 1'b0;
            bin_last  <= 1'b0;
            if (!busy) begin
                if (frame_start) begin
                    busy   <= 1'b1;
                    mac_on <= 1'b1;
                    n      <= '0;
                    k      <= '0;
                end
            end else if (mac_on) begin
                if (last_tap) begin
                    mac_on    <= 1'b0;    // output cycle next
                    n         <= '0;
                    bin_valid <= 1'b1;
                    bin_last  <= last_bin;
                end else begin
                    n <= n + spectrum_pkg::addr_w'(1);
                end
            end else if (bin_last) begin
                busy <= 1'b0;             // frame finished
            end else begin
                k      <= k + spectrum_pkg::addr_w'(1);
                mac_on <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start_frame) begin
            acc_re <= '0;
            acc_im <= '0;
        end else if (mac_on) begin
            if (last_tap) begin
                acc_re <= '0;             // fresh sums for next k
                acc_im <= '0;
                bin.re <= spectrum_pkg::bin_w'(sum_re >>> spectrum_pkg::out_shift);
                bin.im <= spectrum_pkg::bin_w'(sum_im >>> spectrum_pkg::out_shift);
            end else begin
                acc_re <= sum_re;
                acc_im <= sum_im;
            end
        end
    end

endmodule

//--- hw/spectrum_top.sv
`timescale 1ns/1ps

module spectrum_top (
    input  logic                                      clk_in,
    input  logic                                      rst_in,
    input  logic signed [spectrum_pkg::sample_w-1:0]  sample,
    input  logic                                      sample_valid,
    output logic                                      ready,
    output spectrum_pkg::bin_t                        bin,
    output logic                                      bin_valid,
    output logic                                      bin_last
);

    logic                                     wr_en;
    logic        [spectrum_pkg::addr_w-1:0]   wr_addr;
    logic signed [spectrum_pkg::sample_w-1:0] wr_data;
    logic        [spectrum_pkg::addr_w-1:0]   rd_addr;
    logic signed [spectrum_pkg::sample_w-1:0] rd_data;
    logic                                     frame_start;
    logic                                     busy;

    sample_framer u_framer (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .sample       (sample),
        .sample_valid (sample_valid),
        .busy         (busy),
        .ready        (ready),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .frame_start  (frame_start)
    );

    frame_buffer u_buffer (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    dft_engine u_engine (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .frame_start (frame_start),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .busy        (busy),
        .bin         (bin),
        .bin_valid   (bin_valid),
        .bin_last    (bin_last)
    );

endmodule

//--- verif/spectrum_checker.sv
`timescale 1ns/1ps

module spectrum_checker (
    input logic clk_in,
    input logic rst_in,
    input logic frame_start,
    input logic busy,
    input logic bin_valid,
    input logic bin_last
);

    // last marks a bin, never an empty cycle
    last_with_valid: assert property (
        @(posedge clk_in) disable iff (rst_in)
        bin_last |-> bin_valid
    ) else $error("bin_last without bin_valid");

    valid_while_busy: assert property (
        @(posedge clk_in) disable iff (rst_in)
        bin_valid |-> busy
    ) else $error("bin_valid while engine idle");

    // framer must hold off until the frame is done
    no_start_while_busy: assert property (
        @(posedge clk_in) disable iff (rst_in)
        busy |-> !frame_start
    ) else $error("frame_start while engine busy");

endmodule

bind dft_engine spectrum_checker u_checker (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .frame_start (frame_start),
    .busy        (busy),
    .bin_valid   (bin_valid),
    .bin_last    (bin_last)
);

//--- verif/spectrum_tb.sv
`timescale 1ns/1ps

module spectrum_tb;

    localparam int cycles_per_row  = 400;    // watchdog budget per frame
    localparam int first_bin_delay = 18;     // negedges from 16th sample drive to bin 0
    localparam int bin_period      = 17;     // 16 mac cycles and one output cycle

    localparam logic [2:0] kind_impulse = 3'd0;
    localparam logic [2:0] kind_dc      = 3'd1;
    localparam logic [2:0] kind_alt     = 3'd2;
    localparam logic [2:0] kind_cos     = 3'd3;
    localparam logic [2:0] kind_rand    = 3'd4;

    typedef struct packed {
        logic        [2:0]  kind;
        logic signed [7:0]  amp;
        logic signed [31:0] bin0_re;    // real part of bin 0
        logic signed [7:0]  peak;       // -1 leaves the row to the model alone
    } stim_row_t;

    logic                  clk_in = 1'b0;
    logic                  rst_in;
    spectrum_pkg::sample_t sample;
    logic                  sample_valid;
    logic                  ready;
    spectrum_pkg::bin_t    bin;
    logic                  bin_valid;
    logic                  bin_last;

    integer                seed = 32'h71fd;
    bit                    table_ready = 1'b0;
    stim_row_t             rows [$];
    spectrum_pkg::sample_t frame_x [];
    int                    exp_re [];
    int                    exp_im [];

    spectrum_top dut (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .sample       (sample),
        .sample_valid (sample_valid),
        .ready        (ready),
        .bin          (bin),
        .bin_valid    (bin_valid),
        .bin_last     (bin_last)
    );

    always #50 clk_in = ~clk_in;

    task automatic stop_run;
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, expected, actual);
            stop_run();
        end
    endtask

    function automatic stim_row_t make_row(input logic [2:0] kind, input int amp,
                                           input int bin0_re, input int peak);
        stim_row_t row;
        row.kind    = kind;
        row.amp     = 8'(amp);
        row.bin0_re = bin0_re;
        row.peak    = 8'(peak);
        return row;
    endfunction

    task automatic fill_table;
        rows.push_back(make_row(kind_impulse, 100, 6400, 0));     // A*64 in every bin
        rows.push_back(make_row(kind_impulse, -128, -8192, 0));
        rows.push_back(make_row(kind_dc, 50, 51200, 0));          // 16*A*64
        rows.push_back(make_row(kind_dc, -20, -20480, 0));
        rows.push_back(make_row(kind_alt, 60, 0, 8));
        rows.push_back(make_row(kind_cos, 100, -256, 2));         // samples sum to -4
        rows.push_back(make_row(kind_rand, 0, 0, -1));
        rows.push_back(make_row(kind_rand, 0, 0, -1));
    endtask

    function automatic int magnitude(input int re, input int im);
        return ((re < 0) ? -re : re) + ((im < 0) ? -im : im);
    endfunction

    function automatic int scale_to_bin(input int acc);
        logic signed [spectrum_pkg::bin_w-1:0] part;
        part = spectrum_pkg::bin_w'(acc >>> spectrum_pkg::out_shift);
        return int'(part);
    endfunction

    task automatic build_frame(input stim_row_t row);
        int n;
        int a;
        int v;
        int m;
        a = int'($signed(row.amp));
        for (n = 0; n < spectrum_pkg::frame_len; n++) begin
            m = (2 * n) % spectrum_pkg::frame_len;    // tone at bin 2
            case (row.kind)
                kind_impulse: v = (n == 0) ? a : 0;
                kind_dc:      v = a;
                kind_alt:     v = (n % 2 == 0) ? a : -a;
                kind_cos: begin
                    v = a * int'($signed(spectrum_pkg::cos_table[spectrum_pkg::addr_w'(m)]));
                    v = v >>> 14;
                end
                default:      v = $random(seed);
            endcase
            frame_x[n] = spectrum_pkg::sample_t'(v);
        end
    endtask

    // integer DFT straight from the cosine table
    task automatic run_model;
        int k;
        int n;
        int m;
        int s;
        int x;
        int acc_re;
        int acc_im;
        for (k = 0; k < spectrum_pkg::frame_len; k++) begin
            acc_re = 0;
            acc_im = 0;
            for (n = 0; n < spectrum_pkg::frame_len; n++) begin
                m = (n * k) % spectrum_pkg::frame_len;
                s = (m - spectrum_pkg::quarter + spectrum_pkg::frame_len)
                    % spectrum_pkg::frame_len;
                x = int'(frame_x[n]);
                acc_re += x * int'($signed(spectrum_pkg::cos_table[spectrum_pkg::addr_w'(m)]));
                acc_im -= x * int'($signed(spectrum_pkg::cos_table[spectrum_pkg::addr_w'(s)]));
            end
            exp_re[k] = scale_to_bin(acc_re);
            exp_im[k] = scale_to_bin(acc_im);
        end
    endtask

    task automatic send_frame;
        int i;
        for (i = 0; i < spectrum_pkg::frame_len; i++) begin
            @(negedge clk_in);
            while (!ready) begin
                sample_valid = 1'b0;
                @(negedge clk_in);
            end
            sample       = frame_x[i];
            sample_valid = 1'b1;
        end
    endtask

    task automatic collect_bins(input stim_row_t row);
        int cyc;
        int got;
        int last_cyc;
        int peak;
        int peak_hi;
        int best;
        int re;
        int im;
        int mags [];
        mags     = new[spectrum_pkg::frame_len];
        cyc      = 0;
        got      = 0;
        last_cyc = 0;
        peak     = 0;
        peak_hi  = 0;
        best     = -1;
        while (got < spectrum_pkg::frame_len) begin
            @(negedge clk_in);
            cyc++;
            if (bin_valid) begin
                re = int'($signed(bin.re));
                im = int'($signed(bin.im));
                check_value("bin_valid delay", (got == 0) ? first_bin_delay
                            : last_cyc + bin_period, cyc);
                check_value("bin.re", exp_re[got], re);
                check_value("bin.im", exp_im[got], im);
                check_value("bin_last", (got == spectrum_pkg::frame_len - 1) ? 1 : 0,
                            int'(bin_last));
                if (got == 0 && $signed(row.peak) >= 0) begin
                    check_value("bin.re of bin 0", int'($signed(row.bin0_re)), re);
                end
                mags[got] = magnitude(re, im);
                if (mags[got] > best) begin
                    best = mags[got];
                    peak = got;
                end
                if (mags[got] >= best) begin
                    peak_hi = got;    // last bin at the current maximum
                end
                last_cyc = cyc;
                got++;
            end else begin
                check_value("bin_last", 0, int'(bin_last));
            end
            // junk strobes while the engine works must all be dropped
            if (!ready) begin
                sample       = spectrum_pkg::sample_t'($random(seed));
                sample_valid = 1'b1;
            end else begin
                sample_valid = 1'b0;
            end
        end
        @(negedge clk_in);
        check_value("ready", 1, int'(ready));    // opens right after bin_last
        sample_valid = 1'b0;
        if ($signed(row.peak) >= 0) begin
            check_value("peak bin", int'($signed(row.peak)), peak);
        end
        if (row.kind == kind_cos) begin
            check_value("mirror peak bin",
                        spectrum_pkg::frame_len - int'($signed(row.peak)), peak_hi);
        end
    endtask

    initial begin
        wait (table_ready);
        repeat (rows.size() * cycles_per_row) @(posedge clk_in);
        $display("timeout: spectrum not finished after %0d cycles",
                 rows.size() * cycles_per_row);
        stop_run();
    end

    initial begin
        int r;
        rst_in       = 1'b1;
        sample       = '0;
        sample_valid = 1'b0;
        frame_x      = new[spectrum_pkg::frame_len];
        exp_re       = new[spectrum_pkg::frame_len];
        exp_im       = new[spectrum_pkg::frame_len];
        fill_table();
        table_ready = 1'b1;
        repeat (2) @(negedge clk_in);
        rst_in = 1'b0;
        @(negedge clk_in);
        check_value("ready", 1, int'(ready));
        check_value("bin_valid", 0, int'(bin_valid));
        check_value("bin_last", 0, int'(bin_last));
        for (r = 0; r < rows.size(); r++) begin
            build_frame(rows[r]);
            run_model();
            send_frame();
            collect_bins(rows[r]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- files.f
common/spectrum_pkg.sv
hw/sample_framer.sv
dft/frame_buffer.sv
dft/dft_engine.sv
hw/spectrum_top.sv
verif/spectrum_checker.sv
verif/spectrum_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module spectrum_tb -Mdir obj_dir -f files.f

status=0
./obj_dir/Vspectrum_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation passed"
